// File: tests/shift_stage_vectors.txt
# ctl(rst,wbclr,stall,aluclr) flg(dis,cff,cnxt,dav) asrc aval ssrc sval len op midx mval anxt cc dst
# then expected: shifted carry alu_operand store_data cc dst   (all hex)
2 0 1 111 4 C0000005 0 0 2 222 555 e 3 0 0 0 0 f 0
0 4 1 111 4 C0000005 0 0 2 222 555 e 3 C0000005 1 111 222 e 3
0 0 1 111 4 C0000005 1 0 2 222 555 e 3 8000000A 1 111 222 e 3
0 0 1 111 4 C0000005 1f 0 2 222 555 e 3 80000000 0 111 222 e 3
0 0 1 111 4 C0000005 20 0 2 222 555 e 3 0 1 111 222 e 3
0 0 1 111 4 C0000005 21 0 2 222 555 e 3 0 0 111 222 e 3
0 0 1 111 4 C0000005 0 1 2 222 555 e 3 C0000005 0 111 222 e 3
0 0 1 111 4 C0000005 1 1 2 222 555 e 3 60000002 1 111 222 e 3
0 0 1 111 4 C0000005 1f 1 2 222 555 e 3 1 1 111 222 e 3
0 0 1 111 4 C0000005 20 1 2 222 555 e 3 0 1 111 222 e 3
0 0 1 111 4 C0000005 21 1 2 222 555 e 3 0 0 111 222 e 3
0 4 1 111 4 C0000005 0 2 2 222 555 e 3 C0000005 1 111 222 e 3
0 0 1 111 4 C0000005 1 2 2 222 555 e 3 E0000002 1 111 222 e 3
0 0 1 111 4 C0000005 1f 2 2 222 555 e 3 FFFFFFFF 1 111 222 e 3
0 0 1 111 4 C0000005 20 2 2 222 555 e 3 FFFFFFFF 1 111 222 e 3
0 0 1 111 4 C0000005 21 2 2 222 555 e 3 FFFFFFFF 1 111 222 e 3
0 0 1 111 4 40000001 20 2 2 222 555 e 3 0 0 111 222 e 3
0 0 1 111 4 C0000005 0 3 2 222 555 e 3 C0000005 0 111 222 e 3
0 0 1 111 4 C0000005 1 3 2 222 555 e 3 E0000002 1 111 222 e 3
0 0 1 111 4 C0000005 1f 3 2 222 555 e 3 8000000B 1 111 222 e 3
0 0 1 111 4 C0000005 20 3 2 222 555 e 3 C0000005 1 111 222 e 3
0 0 1 111 4 C0000005 21 3 2 222 555 e 3 E0000002 1 111 222 e 3
0 0 1 111 4 C0000005 40 3 2 222 555 e 3 C0000005 1 111 222 e 3
0 0 1 111 4 C0000005 0 4 2 222 555 e 3 60000002 1 111 222 e 3
0 4 1 111 4 C0000005 0 4 2 222 555 e 3 E0000002 1 111 222 e 3
0 a 1 111 4 12345678 0 0 2 222 555 e 3 12345678 1 111 222 e 3
0 8 1000000AB 111 1DEADBEEF 12345678 0 0 2 222 555 e 3 DEADBEEF 0 AB 222 e 3
0 a f 111 f 12345678 0 0 f 222 555 e 3 1008 1 1008 1008 e 3
0 b 3 111 3 777 0 0 3 222 555 e 3 555 1 555 555 e 3
0 a 3 111 3 777 0 0 3 222 555 e 3 777 1 111 222 e 3
0 9 1 111 4 12345678 0 0 2 222 555 e 3 12345678 0 111 222 e 3
0 0 1 111 4 99 0 0 2 222 555 a 3 99 0 111 222 a 3
2 0 1 111 4 AA 0 0 2 222 555 0 5 99 0 111 222 a 3
3 0 1 111 4 AA 0 0 2 222 555 0 5 99 0 111 222 a 3
6 0 1 111 4 AA 0 0 2 222 555 0 5 99 0 111 222 f 0
0 0 1 111 4 BB 0 0 2 222 555 a 3 BB 0 111 222 a 3
1 0 1 111 4 CC 0 0 2 222 555 a 3 CC 0 111 222 f 0
8 0 1 111 4 DD 0 0 2 222 555 a 3 0 0 0 0 f 0
0 0 1 111 4 EE 0 0 2 222 555 e 3 EE 0 111 222 e 3

// File: all.f
+incdir+src
src/shift_stage_pkg.sv
src/barrel_shifter.sv
src/operand_forward.sv
src/shift_stage_regs.sv
src/shift_stage.sv
tests/shift_stage_chk.sv
tests/shift_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= shift_stage_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

SRCS := $(shell grep -v '^+' all.f)
HDRS := $(wildcard src/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): all.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f all.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/shift_stage_tb.sv
// Testbench for the shift stage, driven from a vector file.
// Each vector gives inputs and the outputs expected after the next edge.

`timescale 1ns/1ps

module shift_stage_tb;

import shift_stage_pkg::*;

localparam int MAX_VEC = 256;

logic       i_clk;
logic       i_reset;
logic       i_clear_from_writeback;
logic       i_data_stall;
logic       i_clear_from_alu;
logic       i_disable_shifter;
src_t       i_alu_source;
word_t      i_alu_source_value;
src_t       i_shift_source;
word_t      i_shift_source_value;
word_t      i_shift_length_value;
shift_op_t  i_shift_operation;
logic       i_carry_ff;
logic       i_carry_nxt;
reg_idx_t   i_mem_srcdest_index;
word_t      i_mem_srcdest_value;
word_t      i_alu_value_nxt;
logic       i_alu_dav_nxt;
logic [3:0] i_condition_code;
reg_idx_t   i_destination_index;
alu_op_t    i_alu_operation;
logic       i_flag_update;
word_t      i_pc_plus_8;
word_t      o_shifted_value;
logic       o_shift_carry;
word_t      o_alu_operand;
word_t      o_store_data;
logic [3:0] o_condition_code;
reg_idx_t   o_destination_index;
alu_op_t    o_alu_operation;
logic       o_flag_update;
word_t      o_pc_plus_8;

// One storage array per vector column.
logic [3:0]  ctl_v  [MAX_VEC];
logic [3:0]  flg_v  [MAX_VEC];
logic [32:0] asrc_v [MAX_VEC];
logic [31:0] aval_v [MAX_VEC];
logic [32:0] ssrc_v [MAX_VEC];
logic [31:0] sval_v [MAX_VEC];
logic [7:0]  len_v  [MAX_VEC];
logic [2:0]  op_v   [MAX_VEC];
logic [5:0]  midx_v [MAX_VEC];
logic [31:0] mval_v [MAX_VEC];
logic [31:0] anxt_v [MAX_VEC];
logic [3:0]  cc_v   [MAX_VEC];
logic [5:0]  dst_v  [MAX_VEC];
logic [31:0] esh_v  [MAX_VEC];
logic        ec_v   [MAX_VEC];
logic [31:0] eaop_v [MAX_VEC];
logic [31:0] est_v  [MAX_VEC];
logic [3:0]  ecc_v  [MAX_VEC];
logic [5:0]  edst_v [MAX_VEC];

// Expected pass-through fields, zero after reset and held on a stall.
alu_op_t exp_alu_op;
logic    exp_flag;
word_t   exp_pc;

int vec_count;
int errors;
int cycles;
int cycle_limit;

shift_stage i_shift_stage (.*);

initial
begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
end

// Run length guard.
always @(posedge i_clk)
begin
        cycles++;
end

initial
begin
        wait (cycles > cycle_limit);
        $display("Timeout: the run went past %0d cycles", cycle_limit);
        $display("Something failed");
        $finish;
end

task automatic check_value(input string name, input int vec, input logic [32:0] expected,
                           input logic [32:0] actual);
        if (actual !== expected)
        begin
                errors++;
                $display("[ERROR] %s vector %0d expected %h actual %h",
                         name, vec, expected, actual);
        end
endtask

task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        logic [3:0]  ctl, flg, cc, ecc;
        logic [32:0] asrc, ssrc;
        logic [31:0] aval, sval, mval, anxt, esh, eaop, est;
        logic [7:0]  len;
        logic [2:0]  op;
        logic [5:0]  midx, dst, edst;
        logic        ec;

        fd = $fopen("tests/shift_stage_vectors.txt", "r");
        if (fd == 0)
        begin
                $display("Could not open the vector file tests/shift_stage_vectors.txt");
                errors++;
        end
        else
        begin
                while (!$feof(fd) && vec_count < MAX_VEC)
                begin
                        line = "";
                        void'($fgets(line, fd));
                        if (line.len() < 2 || line[0] == "#")
                        begin
                                continue;
                        end
                        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                    ctl, flg, asrc, aval, ssrc, sval, len, op, midx, mval,
                                    anxt, cc, dst, esh, ec, eaop, est, ecc, edst);
                        if (n != 19)
                        begin
                                $display("Malformed vector line: %s", line);
                                errors++;
                                continue;
                        end
                        ctl_v[vec_count]  = ctl;
                        flg_v[vec_count]  = flg;
                        asrc_v[vec_count] = asrc;
                        aval_v[vec_count] = aval;
                        ssrc_v[vec_count] = ssrc;
                        sval_v[vec_count] = sval;
                        len_v[vec_count]  = len;
                        op_v[vec_count]   = op;
                        midx_v[vec_count] = midx;
                        mval_v[vec_count] = mval;
                        anxt_v[vec_count] = anxt;
                        cc_v[vec_count]   = cc;
                        dst_v[vec_count]  = dst;
                        esh_v[vec_count]  = esh;
                        ec_v[vec_count]   = ec;
                        eaop_v[vec_count] = eaop;
                        est_v[vec_count]  = est;
                        ecc_v[vec_count]  = ecc;
                        edst_v[vec_count] = edst;
                        vec_count++;
                end
                $fclose(fd);
        end
endtask

task automatic apply_vector(input int k);
        i_reset                = ctl_v[k][3];
        i_clear_from_writeback = ctl_v[k][2];
        i_data_stall           = ctl_v[k][1];
        i_clear_from_alu       = ctl_v[k][0];
        i_disable_shifter      = flg_v[k][3];
        i_carry_ff             = flg_v[k][2];
        i_carry_nxt            = flg_v[k][1];
        i_alu_dav_nxt          = flg_v[k][0];
        i_alu_source           = asrc_v[k];
        i_alu_source_value     = aval_v[k];
        i_shift_source         = ssrc_v[k];
        i_shift_source_value   = sval_v[k];
        // Only the low byte sets the amount.
        i_shift_length_value   = {24'($urandom), len_v[k]};
        i_shift_operation      = shift_op_t'(op_v[k]);
        i_mem_srcdest_index    = midx_v[k];
        i_mem_srcdest_value    = mval_v[k];
        i_alu_value_nxt        = anxt_v[k];
        i_condition_code       = cc_v[k];
        i_destination_index    = dst_v[k];
        i_alu_operation        = alu_op_t'(4'($urandom));
        i_flag_update          = 1'($urandom);
endtask

// Fields that pass straight through follow the inputs of the last edge.
task automatic model_passthrough();
        if (i_reset)
        begin
                exp_alu_op = AND;
                exp_flag   = 1'b0;
                exp_pc     = '0;
        end
        else if (!i_data_stall)
        begin
                exp_alu_op = i_alu_operation;
                exp_flag   = i_flag_update;
                exp_pc     = i_pc_plus_8;
        end
endtask

task automatic check_vector(input int k);
        check_value("shifted_value", k, 33'(esh_v[k]), 33'(o_shifted_value));
        check_value("shift_carry", k, 33'(ec_v[k]), 33'(o_shift_carry));
        check_value("alu_operand", k, 33'(eaop_v[k]), 33'(o_alu_operand));
        check_value("store_data", k, 33'(est_v[k]), 33'(o_store_data));
        check_value("condition_code", k, 33'(ecc_v[k]), 33'(o_condition_code));
        check_value("destination_index", k, 33'(edst_v[k]), 33'(o_destination_index));
        check_value("alu_operation", k, 33'(exp_alu_op), 33'(o_alu_operation));
        check_value("flag_update", k, 33'(exp_flag), 33'(o_flag_update));
        check_value("pc_plus_8", k, 33'(exp_pc), 33'(o_pc_plus_8));
endtask

initial
begin
        void'($urandom(32'h919ce42a));
        errors      = 0;
        cycles      = 0;
        vec_count   = 0;
        cycle_limit = 1000;

        i_reset                = 1'b1;
        i_clear_from_writeback = 1'b0;
        i_data_stall           = 1'b0;
        i_clear_from_alu       = 1'b0;
        i_disable_shifter      = 1'b0;
        i_alu_source           = '0;
        i_alu_source_value     = '0;
        i_shift_source         = '0;
        i_shift_source_value   = '0;
        i_shift_length_value   = '0;
        i_shift_operation      = LSL;
        i_carry_ff             = 1'b0;
        i_carry_nxt            = 1'b0;
        i_mem_srcdest_index    = '0;
        i_mem_srcdest_value    = '0;
        i_alu_value_nxt        = '0;
        i_alu_dav_nxt          = 1'b0;
        i_condition_code       = 4'hf;
        i_destination_index    = '0;
        i_alu_operation        = AND;
        i_flag_update          = 1'b0;
        i_pc_plus_8            = 32'h0000_1008;

        exp_alu_op = AND;
        exp_flag   = 1'b0;
        exp_pc     = '0;

        load_vectors();
        cycle_limit = vec_count + 20;

        repeat (2) @(posedge i_clk);
        #1;
        if (vec_count > 0)
        begin
                apply_vector(0);
        end
        for (int k = 0; k < vec_count; k++)
        begin
                @(posedge i_clk);
                #1;
                model_passthrough();
                check_vector(k);
                if (k + 1 < vec_count)
                begin
                        apply_vector(k + 1);
                end
        end

        $display("Checks done: %0d vectors, %0d errors", vec_count, errors);
        if (errors == 0 && vec_count > 0)
        begin
                $display("Everything OK");
        end
        else
        begin
                $display("Something failed");
        end
        $finish;
end

endmodule

// File: tests/shift_stage_chk.sv
// Assertions on the clear, stall and bubble rules of the stage register.
// Bound to shift_stage_regs at the bottom of this file.

`timescale 1ns/1ps

`include "shift_stage_cfg.svh"

module shift_stage_chk
(
        input  logic                      i_clk,
        input  logic                      i_reset,
        input  logic                      i_clear_from_writeback,
        input  logic                      i_data_stall,
        input  logic                      i_clear_from_alu,
        input  logic [3:0]                i_cc_q,
        input  shift_stage_pkg::reg_idx_t i_dest_q
);

import shift_stage_pkg::*;

// Reset leaves a bubble with destination 0.
reset_gives_bubble: assert property (@(posedge i_clk)
        i_reset |=> (i_cc_q == 4'(`SS_COND_NV)) && (i_dest_q == '0))
        else $error("reset did not leave a bubble with destination 0");

// Either effective clear turns the slot into a bubble.
clear_gives_bubble: assert property (@(posedge i_clk)
        (i_clear_from_writeback || (i_clear_from_alu && !i_data_stall))
        |=> (i_cc_q == 4'(`SS_COND_NV)))
        else $error("effective clear did not produce condition code NV");

// A stall without writeback clear holds the condition code.
stall_holds_cc: assert property (@(posedge i_clk)
        (i_data_stall && !i_clear_from_writeback && !i_reset) |=> $stable(i_cc_q))
        else $error("condition code changed during a stall");

endmodule

bind shift_stage_regs shift_stage_chk u_chk
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_cc_q                 (o_condition_code),
        .i_dest_q               (o_destination_index)
);

// File: src/shift_stage.sv
// Top level of the shift stage.
// Connects the barrel shifter, three forwarding units and the stage register.

`timescale 1ns/1ps

`include "shift_stage_cfg.svh"

module shift_stage
(
        input  logic                       i_clk,
        input  logic                       i_reset,
        input  logic                       i_clear_from_writeback,
        input  logic                       i_data_stall,
        input  logic                       i_clear_from_alu,
        input  logic                       i_disable_shifter,
        input  shift_stage_pkg::src_t      i_alu_source,
        input  shift_stage_pkg::word_t     i_alu_source_value,
        input  shift_stage_pkg::src_t      i_shift_source,
        input  shift_stage_pkg::word_t     i_shift_source_value,
        input  shift_stage_pkg::word_t     i_shift_length_value,
        input  shift_stage_pkg::shift_op_t i_shift_operation,
        input  logic                       i_carry_ff,
        input  logic                       i_carry_nxt,
        input  shift_stage_pkg::reg_idx_t  i_mem_srcdest_index,
        input  shift_stage_pkg::word_t     i_mem_srcdest_value,
        input  shift_stage_pkg::word_t     i_alu_value_nxt,
        input  logic                       i_alu_dav_nxt,
        input  logic [3:0]                 i_condition_code,
        input  shift_stage_pkg::reg_idx_t  i_destination_index,
        input  shift_stage_pkg::alu_op_t   i_alu_operation,
        input  logic                       i_flag_update,
        input  shift_stage_pkg::word_t     i_pc_plus_8,
        output shift_stage_pkg::word_t     o_shifted_value,
        output logic                       o_shift_carry,
        output shift_stage_pkg::word_t     o_alu_operand,
        output shift_stage_pkg::word_t     o_store_data,
        output logic [3:0]                 o_condition_code,
        output shift_stage_pkg::reg_idx_t  o_destination_index,
        output shift_stage_pkg::alu_op_t   o_alu_operation,
        output logic                       o_flag_update,
        output shift_stage_pkg::word_t     o_pc_plus_8
);

import shift_stage_pkg::*;

word_t shift_out;
logic  shift_carry;
word_t alu_operand;
word_t shift_bypass;
word_t store_data;
src_t  store_source;

// Store index never carries an immediate.
assign store_source = {{(`SS_SRC_W - `SS_IDX_W){1'b0}}, i_mem_srcdest_index};

////////////////////////////////////////////////////////////////////////////

// Shifter works on the issue value of the shift source.
barrel_shifter u_barrel_shifter
(
        .i_source     (i_shift_source_value),
        .i_amount     (i_shift_length_value[7:0]),
        .i_shift_type (i_shift_operation),
        .i_carry      (i_carry_ff),
        .o_result     (shift_out),
        .o_carry      (shift_carry)
);

operand_forward u_alu_fwd
(
        .i_source      (i_alu_source),
        .i_issue_value (i_alu_source_value),
        .i_pc_plus_8   (i_pc_plus_8),
        .i_stage_dest  (o_destination_index),
        .i_alu_value   (i_alu_value_nxt),
        .i_alu_valid   (i_alu_dav_nxt),
        .o_value       (alu_operand)
);

operand_forward u_shift_fwd
(
        .i_source      (i_shift_source),
        .i_issue_value (i_shift_source_value),
        .i_pc_plus_8   (i_pc_plus_8),
        .i_stage_dest  (o_destination_index),
        .i_alu_value   (i_alu_value_nxt),
        .i_alu_valid   (i_alu_dav_nxt),
        .o_value       (shift_bypass)
);

operand_forward u_store_fwd
(
        .i_source      (store_source),
        .i_issue_value (i_mem_srcdest_value),
        .i_pc_plus_8   (i_pc_plus_8),
        .i_stage_dest  (o_destination_index),
        .i_alu_value   (i_alu_value_nxt),
        .i_alu_valid   (i_alu_dav_nxt),
        .o_value       (store_data)
);

////////////////////////////////////////////////////////////////////////////

shift_stage_regs u_regs
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_disable_shifter      (i_disable_shifter),
        .i_shift_result         (shift_out),
        .i_shift_carry          (shift_carry),
        .i_bypass_value         (shift_bypass),
        .i_carry_nxt            (i_carry_nxt),
        .i_alu_operand          (alu_operand),
        .i_store_data           (store_data),
        .i_condition_code       (i_condition_code),
        .i_destination_index    (i_destination_index),
        .i_alu_operation        (i_alu_operation),
        .i_flag_update          (i_flag_update),
        .i_pc_plus_8            (i_pc_plus_8),
        .o_shifted_value        (o_shifted_value),
        .o_shift_carry          (o_shift_carry),
        .o_alu_operand          (o_alu_operand),
        .o_store_data           (o_store_data),
        .o_condition_code       (o_condition_code),
        .o_destination_index    (o_destination_index),
        .o_alu_operation        (o_alu_operation),
        .o_flag_update          (o_flag_update),
        .o_pc_plus_8            (o_pc_plus_8)
);

endmodule

// File: src/shift_stage_regs.sv
// Result select and output register of the shift stage.
// Priority is reset, writeback clear, stall, then ALU clear.

`timescale 1ns/1ps

`include "shift_stage_cfg.svh"

module shift_stage_regs
(
        input  logic                      i_clk,
        input  logic                      i_reset,
        input  logic                      i_clear_from_writeback,
        input  logic                      i_data_stall,
        input  logic                      i_clear_from_alu,
        input  logic                      i_disable_shifter,
        input  shift_stage_pkg::word_t    i_shift_result,
        input  logic                      i_shift_carry,
        input  shift_stage_pkg::word_t    i_bypass_value,
        input  logic                      i_carry_nxt,
        input  shift_stage_pkg::word_t    i_alu_operand,
        input  shift_stage_pkg::word_t    i_store_data,
        input  logic [3:0]                i_condition_code,
        input  shift_stage_pkg::reg_idx_t i_destination_index,
        input  shift_stage_pkg::alu_op_t  i_alu_operation,
        input  logic                      i_flag_update,
        input  shift_stage_pkg::word_t    i_pc_plus_8,
        output shift_stage_pkg::word_t    o_shifted_value,
        output logic                      o_shift_carry,
        output shift_stage_pkg::word_t    o_alu_operand,
        output shift_stage_pkg::word_t    o_store_data,
        output logic [3:0]                o_condition_code,
        output shift_stage_pkg::reg_idx_t o_destination_index,
        output shift_stage_pkg::alu_op_t  o_alu_operation,
        output logic                      o_flag_update,
        output shift_stage_pkg::word_t    o_pc_plus_8
);

import shift_stage_pkg::*;

word_t shifted_nxt;
logic  carry_sel;
logic  clear;

// ALU clear is ignored while the stage is stalled.
assign clear = i_clear_from_writeback | (i_clear_from_alu & ~i_data_stall);

// Disabled shifter passes the forwarded source and the next flags carry.
assign shifted_nxt = i_disable_shifter ? i_bypass_value : i_shift_result;
assign carry_sel   = i_disable_shifter ? i_carry_nxt    : i_shift_carry;

////////////////////////////////////////////////////////////////////////////

// Control fields, a clear turns the slot into a bubble.
always_ff @(posedge i_clk)
begin
        if (i_reset || clear)
        begin
                o_condition_code    <= 4'(`SS_COND_NV);
                o_destination_index <= '0;
        end
        else if (!i_data_stall)
        begin
                o_condition_code    <= i_condition_code;
                o_destination_index <= i_destination_index;
        end
end

////////////////////////////////////////////////////////////////////////////

// Payload fields.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_shifted_value <= '0;
                o_shift_carry   <= 1'b0;
                o_alu_operand   <= '0;
                o_store_data    <= '0;
                o_alu_operation <= AND;
                o_flag_update   <= 1'b0;
                o_pc_plus_8     <= '0;
        end
        else if (!i_data_stall)
        begin
                o_shifted_value <= shifted_nxt;
                o_shift_carry   <= carry_sel;
                o_alu_operand   <= i_alu_operand;
                o_store_data    <= i_store_data;
                o_alu_operation <= i_alu_operation;
                o_flag_update   <= i_flag_update;
                o_pc_plus_8     <= i_pc_plus_8;
        end
end

endmodule

// File: src/operand_forward.sv
// Picks the newest value of one operand for back to back instructions.
// Order is immediate, PC, ALU result of the instruction ahead, issue read.

`timescale 1ns/1ps

`include "shift_stage_cfg.svh"

module operand_forward
(
        input  shift_stage_pkg::src_t     i_source,
        input  shift_stage_pkg::word_t    i_issue_value,
        input  shift_stage_pkg::word_t    i_pc_plus_8,
        input  shift_stage_pkg::reg_idx_t i_stage_dest,
        input  shift_stage_pkg::word_t    i_alu_value,
        input  logic                      i_alu_valid,
        output shift_stage_pkg::word_t    o_value
);

import shift_stage_pkg::*;

reg_idx_t src_idx;

assign src_idx = i_source[`SS_IDX_W-1:0];

always_comb
begin
        if (i_source[`SS_IMM_BIT])
        begin
                o_value = i_source[`SS_DATA_W-1:0];
        end
        else if (src_idx == `SS_IDX_W'(`SS_PC_IDX))
        begin
                o_value = i_pc_plus_8;
        end
        else if (src_idx == i_stage_dest && i_alu_valid)
        begin
                // Instruction ahead writes this register, take its result.
                o_value = i_alu_value;
        end
        else
        begin
                o_value = i_issue_value;
        end
end

endmodule

// File: src/barrel_shifter.sv
// Combinational ARM barrel shifter with carry out.
// Handles LSL, LSR, ASR, ROR and RRX with amounts 0 to 255.

`timescale 1ns/1ps

module barrel_shifter
(
        input  shift_stage_pkg::word_t     i_source,
        input  logic [7:0]                 i_amount,
        input  shift_stage_pkg::shift_op_t i_shift_type,
        input  logic                       i_carry,
        output shift_stage_pkg::word_t     o_result,
        output logic                       o_carry
);

import shift_stage_pkg::*;

logic        [32:0] lsl_ext;
logic        [32:0] lsr_ext;
logic signed [32:0] asr_ext;
logic        [63:0] ror_pair;

// Carry rides along as an extra bit, so 32 and above fall out naturally.
assign lsl_ext  = {1'b0, i_source} << i_amount;
assign lsr_ext  = {i_source, 1'b0} >> i_amount;
assign asr_ext  = $signed({i_source, 1'b0}) >>> i_amount;

// Rotate uses only amount mod 32.
assign ror_pair = {i_source, i_source} >> i_amount[4:0];

always_comb
begin
        o_result = i_source;
        o_carry  = i_carry;

        case (i_shift_type)
        LSL:
        begin
                if (i_amount != 8'd0)
                begin
                        {o_carry, o_result} = lsl_ext;
                end
        end
        LSR:
        begin
                if (i_amount != 8'd0)
                begin
                        {o_result, o_carry} = lsr_ext;
                end
        end
        ASR:
        begin
                if (i_amount != 8'd0)
                begin
                        {o_result, o_carry} = asr_ext;
                end
        end
        ROR:
        begin
                // Multiples of 32 leave the source and copy bit 31 to carry.
                if (i_amount != 8'd0)
                begin
                        o_result = ror_pair[31:0];
                        o_carry  = ror_pair[31];
                end
        end
        RRX:
        begin
                o_result = {i_carry, i_source[31:1]};
                o_carry  = i_source[0];
        end
        default:
        begin
                o_result = i_source;
                o_carry  = i_carry;
        end
        endcase
end

endmodule

// File: src/shift_stage_pkg.sv
// Shared types for the shift stage.
// Modules refer to these by scoped name in ports and import them in the body.

`include "shift_stage_cfg.svh"

package shift_stage_pkg;

typedef logic [`SS_DATA_W-1:0] word_t;
typedef logic [`SS_IDX_W-1:0]  reg_idx_t;

// Either a register index or an immediate, flagged by the top bit.
typedef logic [`SS_SRC_W-1:0]  src_t;

typedef enum logic [2:0] {
        LSL = 3'd0,
        LSR = 3'd1,
        ASR = 3'd2,
        ROR = 3'd3,
        RRX = 3'd4
} shift_op_t;

// Data processing opcodes, in instruction encoding order.
typedef enum logic [3:0] {
        AND, EOR, SUB, RSB,
        ADD, ADC, SBC, RSC,
        TST, TEQ, CMP, CMN,
        ORR, MOV, BIC, MVN
} alu_op_t;

endpackage

// File: src/shift_stage_cfg.svh
// Fixed widths and encodings for the shift stage.
// Included by the package and by any module that needs these constants.

`ifndef SHIFT_STAGE_CFG_SVH
`define SHIFT_STAGE_CFG_SVH

// Data word width.
`define SS_DATA_W 32

// Physical register index width, wide enough for 46 registers.
`define SS_IDX_W 6

// Physical index that reads as the PC.
`define SS_PC_IDX 15

// Condition code that marks a bubble.
`define SS_COND_NV 15

// Source field is a data word plus an immediate flag on top.
`define SS_SRC_W (`SS_DATA_W + 1)

// Bit position of the immediate flag in a source field.
`define SS_IMM_BIT `SS_DATA_W

`endif
